// ==== common/list_walk_pkg.sv ====
/*
 * List walker shared definitions
 * Widths, CSR indices, walker states and the host request and response types
 */

package list_walk_pkg;

    // ==================================================
    // Address and bus widths
    // ==================================================

    // Host byte address width
    localparam int BYTE_ADDR_BITS = 48;
    // Low zero bits between a byte address and a line address (64-byte lines)
    localparam int BYTE_IDX_BITS = 6;
    localparam int LINE_ADDR_BITS = BYTE_ADDR_BITS - BYTE_IDX_BITS;
    // Only the low 96 bits of a line carry anything this design looks at
    localparam int LINE_BITS = 128;

    // ==================================================
    // CSR map
    // ==================================================

    localparam int CSR_IDX_BITS = 1;
    localparam int CSR_DATA_BITS = 64;

    // Write sets the result address, read returns the record read count
    localparam logic [CSR_IDX_BITS-1:0] CSR_RESULT_ADDR = 1'b0;
    // Write starts a walk, read returns the data word count of the walk
    localparam logic [CSR_IDX_BITS-1:0] CSR_START = 1'b1;

    // Each list record spans this many lines, read as one request
    localparam int LINES_PER_RECORD = 4;

    // Beat number within a record read response
    typedef logic [$clog2(LINES_PER_RECORD)-1:0] t_cl_num;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_RUN,
        ST_END_OF_LIST,
        ST_WRITE_RESULT
    } t_walk_state;

    typedef struct packed
    {
        logic en;
        logic [CSR_IDX_BITS-1:0] idx;
        logic [CSR_DATA_BITS-1:0] data;
    } t_csr_wr;

    // Read request that always covers a whole record
    typedef struct packed
    {
        logic valid;
        logic [LINE_ADDR_BITS-1:0] line_addr;
    } t_rd_req;

    typedef struct packed
    {
        logic valid;
        t_cl_num cl_num;
        logic [LINE_BITS-1:0] data;
    } t_rd_rsp;

    typedef struct packed
    {
        logic valid;
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [LINE_BITS-1:0] data;
    } t_wr_req;

    // Low 64 bits of a response line, decoded by beat number
    // Line 0 holds the next pointer, lines 1 to 3 hold a data word
    typedef union packed
    {
        struct packed
        {
            logic [63-BYTE_ADDR_BITS:0] pad;
            logic [BYTE_ADDR_BITS-1:0] byte_addr;
        } next;
        struct packed
        {
            logic [31:0] pad;
            logic [31:0] value;
        } word;
    } t_line_word;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the list walker testbench with Verilator.
# Exits nonzero if the build or the run fails, or if the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_list_walk \
    -f sim.f -Mdir obj_dir -o Vtb_list_walk
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_list_walk > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
common/list_walk_pkg.sv
source/csr_regs.sv
walker/walk_fsm.sv
walker/read_issuer.sv
walker/rsp_decode.sv
walker/hash32.sv
source/list_walk_top.sv
sim/host_mem_model.sv
sim/tb_list_walk.sv

// ==== sim/host_mem_model.sv ====
/*
 * Host memory model for the list walker testbench
 * Answers four-line record reads after a random delay and captures result writes
 */

`timescale 1ns/1ps

module host_mem_model
(
    input  logic clk,
    input  logic reset,
    input  logic bp_enable,
    input  list_walk_pkg::t_rd_req rd_req,
    output list_walk_pkg::t_rd_rsp rd_rsp,
    output logic c0_alm_full,
    input  list_walk_pkg::t_wr_req wr_req,
    output logic c1_alm_full,
    output int wr_count,
    output logic [list_walk_pkg::LINE_ADDR_BITS-1:0] last_wr_line,
    output int protocol_errors
);

    typedef logic [list_walk_pkg::LINE_ADDR_BITS-1:0] t_line_addr;

    // Sparse memory with one entry per line address
    logic [list_walk_pkg::LINE_BITS-1:0] lines [t_line_addr];
    t_line_addr rd_queue [$];

    // Record read being answered
    t_line_addr cur_line;
    logic busy;
    logic [1:0] beat;
    int unsigned gap;

    // Almost-full values seen in the cycle before the current one
    logic c0_seen;
    logic c1_seen;

    // Back-pressure enable as it stood at the clock edge
    logic bp_on;

    task automatic store_line(input t_line_addr line_addr, input logic [127:0] data);
        lines[line_addr] = data;
    endtask

    // Lines that were never written read back as zero
    function automatic logic [127:0] read_line(input t_line_addr line_addr);
        if (lines.exists(line_addr))
        begin
            return lines[line_addr];
        end
        return '0;
    endfunction

    initial
    begin
        rd_rsp = '0;
        c0_alm_full = 1'b0;
        c1_alm_full = 1'b0;
        wr_count = 0;
        last_wr_line = '0;
        protocol_errors = 0;
        cur_line = '0;
        busy = 1'b0;
        beat = 2'd0;
        gap = 0;
        c0_seen = 1'b0;
        c1_seen = 1'b0;
        bp_on = 1'b0;
        forever
        begin
            // ==================================================
            // Sample requests at the clock edge
            // ==================================================
            @(posedge clk);
            if (!reset)
            begin
                if (rd_req.valid)
                begin
                    // A request must follow a cycle with the channel open
                    if (c0_seen)
                    begin
                        $display("Read request right after the read channel was almost full");
                        protocol_errors++;
                    end
                    rd_queue.push_back(rd_req.line_addr);
                end
                if (wr_req.valid)
                begin
                    if (c1_seen)
                    begin
                        $display("Write request right after the write channel was almost full");
                        protocol_errors++;
                    end
                    lines[wr_req.line_addr] = wr_req.data;
                    last_wr_line = wr_req.line_addr;
                    wr_count++;
                end
            end
            c0_seen = c0_alm_full;
            c1_seen = c1_alm_full;
            bp_on = bp_enable;

            // ==================================================
            // Drive responses just after the edge
            // ==================================================
            #1;
            rd_rsp = '0;
            if (busy)
            begin
                if (gap == 0)
                begin
                    rd_rsp.valid = 1'b1;
                    rd_rsp.cl_num = beat;
                    rd_rsp.data = read_line(cur_line + t_line_addr'(beat));
                    if (beat == 2'd3)
                    begin
                        busy = 1'b0;
                    end
                    else
                    begin
                        beat = beat + 2'd1;
                        // Gap of up to three idle cycles before the next beat
                        gap = $urandom_range(3, 0);
                    end
                end
                else
                begin
                    gap--;
                end
            end
            else if (rd_queue.size() > 0)
            begin
                // First beat comes 1 to 4 cycles after the request
                cur_line = rd_queue.pop_front();
                busy = 1'b1;
                beat = 2'd0;
                gap = $urandom_range(3, 0);
            end

            // Each channel is almost full about a quarter of the time
            if (bp_on)
            begin
                c0_alm_full = ($urandom_range(3, 0) == 0);
                c1_alm_full = ($urandom_range(3, 0) == 0);
            end
            else
            begin
                c0_alm_full = 1'b0;
                c1_alm_full = 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_list_walk.sv ====
/*
 * Testbench for the linked-list walker
 * Builds lists in host memory, walks them and checks the result lines and CSRs
 */

`timescale 1ns/1ps

module tb_list_walk;

    typedef logic [list_walk_pkg::LINE_ADDR_BITS-1:0] t_line_addr;

    // Budget for about 40 record reads at up to 500 cycles each
    localparam int MAX_RECORD_READS = 40;
    localparam int CYCLES_PER_READ = 500;
    localparam int TIMEOUT_CYCLES = MAX_RECORD_READS * CYCLES_PER_READ;

    logic clk;
    logic reset;
    list_walk_pkg::t_csr_wr csr_wr;
    logic [list_walk_pkg::CSR_IDX_BITS-1:0] csr_rd_idx;
    logic [list_walk_pkg::CSR_DATA_BITS-1:0] csr_rd_data;
    list_walk_pkg::t_rd_req rd_req;
    list_walk_pkg::t_rd_rsp rd_rsp;
    list_walk_pkg::t_wr_req wr_req;
    logic c0_alm_full;
    logic c1_alm_full;

    // Memory model controls and observations
    logic bp_enable;
    int wr_count;
    t_line_addr last_wr_line;
    int protocol_errors;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    // Record reads the DUT should have issued since reset
    int total_reads = 0;
    logic [31:0] five_hash;

    list_walk_top i_list_walk_top
    (
        .clk         (clk),
        .reset       (reset),
        .csr_wr      (csr_wr),
        .csr_rd_idx  (csr_rd_idx),
        .csr_rd_data (csr_rd_data),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .c0_alm_full (c0_alm_full),
        .wr_req      (wr_req),
        .c1_alm_full (c1_alm_full)
    );

    host_mem_model host_mem
    (
        .clk             (clk),
        .reset           (reset),
        .bp_enable       (bp_enable),
        .rd_req          (rd_req),
        .rd_rsp          (rd_rsp),
        .c0_alm_full     (c0_alm_full),
        .wr_req          (wr_req),
        .c1_alm_full     (c1_alm_full),
        .wr_count        (wr_count),
        .last_wr_line    (last_wr_line),
        .protocol_errors (protocol_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the walks did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("Mismatch %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    // One hash step rotates left by 5 and XORs in the data word
    function automatic logic [31:0] rotate_mix(input logic [31:0] h, input logic [31:0] w);
        return {h[26:0], h[31:27]} ^ w;
    endfunction

    task automatic csr_write(input logic [0:0] idx, input logic [63:0] data);
        @(posedge clk);
        #1;
        csr_wr.en = 1'b1;
        csr_wr.idx = idx;
        csr_wr.data = data;
        @(posedge clk);
        #1;
        csr_wr.en = 1'b0;
    endtask

    task automatic check_csr(input logic [0:0] idx, input logic [63:0] expected,
                             input string name);
        @(posedge clk);
        #1;
        csr_rd_idx = idx;
        // The read is combinational, so it settles well before this point
        #2;
        check_value(name, 128'(csr_rd_data), 128'(expected));
    endtask

    // Records sit eight lines apart, line 0 links on and lines 1 to 3 carry data.
    // Upper line bits and the pad above each word are filled with noise
    task automatic build_list(input t_line_addr first_line, input int records,
                              output logic [31:0] hash);
        t_line_addr line;
        t_line_addr next_line;
        logic [31:0] word;
        int i;
        int j;
        hash = '0;
        line = first_line;
        for (i = 0; i < records; i++)
        begin
            next_line = (i == records - 1) ? '0 : line + t_line_addr'(8);
            host_mem.store_line(line, {$urandom, $urandom, 16'h0, next_line, 6'h0});
            for (j = 1; j < 4; j++)
            begin
                word = $urandom;
                host_mem.store_line(line + t_line_addr'(j), {$urandom, $urandom, $urandom, word});
                hash = rotate_mix(hash, word);
            end
            line = next_line;
        end
        total_reads += records;
    endtask

    // Starts a walk, waits for its result write and checks the line it wrote
    task automatic run_walk(input t_line_addr result_line, input t_line_addr first_line,
                            input logic [31:0] hash);
        int writes_before;
        writes_before = wr_count;
        csr_write(list_walk_pkg::CSR_RESULT_ADDR, {16'h0, result_line, 6'h0});
        csr_write(list_walk_pkg::CSR_START, {16'h0, first_line, 6'h0});
        while (wr_count == writes_before)
        begin
            @(negedge clk);
        end
        // Leave room for a second, unwanted write to show up
        repeat (20) @(negedge clk);
        check_value("wr_req.valid count", 128'(wr_count - writes_before), 128'd1);
        check_value("wr_req.line_addr", 128'(last_wr_line), 128'(result_line));
        check_value("wr_req.data", host_mem.read_line(result_line), {32'h0, hash, 64'd1});
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_reset_state();
        check_value("rd_req.valid", 128'(rd_req.valid), 128'd0);
        check_value("wr_req.valid", 128'(wr_req.valid), 128'd0);
        check_csr(list_walk_pkg::CSR_RESULT_ADDR, 64'd0, "csr_rd_data (read count)");
        check_csr(list_walk_pkg::CSR_START, 64'd0, "csr_rd_data (data count)");
    endtask

    task automatic test_single_record();
        logic [31:0] hash;
        build_list(t_line_addr'('h1000), 1, hash);
        run_walk(t_line_addr'('h100), t_line_addr'('h1000), hash);
        check_csr(list_walk_pkg::CSR_START, 64'd3, "csr_rd_data (data count)");
        check_csr(list_walk_pkg::CSR_RESULT_ADDR, 64'(total_reads), "csr_rd_data (read count)");
    endtask

    task automatic test_five_records();
        build_list(t_line_addr'('h2000), 5, five_hash);
        run_walk(t_line_addr'('h140), t_line_addr'('h2000), five_hash);
        check_csr(list_walk_pkg::CSR_START, 64'd15, "csr_rd_data (data count)");
        check_csr(list_walk_pkg::CSR_RESULT_ADDR, 64'(total_reads), "csr_rd_data (read count)");
    endtask

    // Walks the five-record list again with both channels throttled
    task automatic test_back_pressure();
        @(posedge clk);
        #1;
        bp_enable = 1'b1;
        total_reads += 5;
        run_walk(t_line_addr'('h180), t_line_addr'('h2000), five_hash);
        check_value("protocol_errors", 128'(protocol_errors), 128'd0);
        check_csr(list_walk_pkg::CSR_START, 64'd15, "csr_rd_data (data count)");
        check_csr(list_walk_pkg::CSR_RESULT_ADDR, 64'(total_reads), "csr_rd_data (read count)");
        @(posedge clk);
        #1;
        bp_enable = 1'b0;
    endtask

    // A fresh walk must hash from zero and leave the old result alone
    task automatic test_second_walk();
        logic [31:0] hash;
        build_list(t_line_addr'('h3000), 2, hash);
        run_walk(t_line_addr'('h1c0), t_line_addr'('h3000), hash);
        check_value("wr_req.data (old result line)", host_mem.read_line(t_line_addr'('h180)),
                    {32'h0, five_hash, 64'd1});
        check_csr(list_walk_pkg::CSR_START, 64'd6, "csr_rd_data (data count)");
        check_csr(list_walk_pkg::CSR_RESULT_ADDR, 64'(total_reads), "csr_rd_data (read count)");
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        void'($urandom(32'h888b));
        csr_wr = '0;
        csr_rd_idx = '0;
        bp_enable = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_single_record();
        test_five_records();
        test_back_pressure();
        test_second_walk();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== source/csr_regs.sv ====
/*
 * CSR block for the list walker
 * Captures the result and start addresses and returns the status counters
 */

`timescale 1ns/1ps

module csr_regs
(
    input  logic clk,
    input  list_walk_pkg::t_csr_wr csr_wr,
    input  logic [list_walk_pkg::CSR_IDX_BITS-1:0] csr_rd_idx,
    input  logic [15:0] list_length,
    input  logic [15:0] data_count,
    output logic [list_walk_pkg::CSR_DATA_BITS-1:0] csr_rd_data,
    output logic [list_walk_pkg::LINE_ADDR_BITS-1:0] result_line_addr,
    output logic start,
    output logic [list_walk_pkg::LINE_ADDR_BITS-1:0] start_line_addr
);

    // Line address taken out of the written byte address by dropping the
    // low zero bits
    logic [list_walk_pkg::LINE_ADDR_BITS-1:0] wr_line_addr;

    assign wr_line_addr =
        csr_wr.data[list_walk_pkg::BYTE_IDX_BITS +: list_walk_pkg::LINE_ADDR_BITS];

    // ==================================================
    // Write side
    // ==================================================

    always_ff @(posedge clk)
    begin
        // The result address is held until software writes it again
        if (csr_wr.en && (csr_wr.idx == list_walk_pkg::CSR_RESULT_ADDR))
        begin
            result_line_addr <= wr_line_addr;
        end

        // A CSR 1 write becomes a single-cycle start pulse one cycle later,
        // with the first record address captured alongside it
        start <= csr_wr.en && (csr_wr.idx == list_walk_pkg::CSR_START);
        start_line_addr <= wr_line_addr;
    end

    // ==================================================
    // Read side
    // ==================================================

    // Reads are combinational and show the counters every cycle
    always_comb
    begin
        if (csr_rd_idx == list_walk_pkg::CSR_RESULT_ADDR)
        begin
            // Record reads issued since reset
            csr_rd_data = {{(list_walk_pkg::CSR_DATA_BITS - 16){1'b0}}, list_length};
        end
        else
        begin
            // Data words hashed in the current walk
            csr_rd_data = {{(list_walk_pkg::CSR_DATA_BITS - 16){1'b0}}, data_count};
        end
    end

endmodule

// ==== source/list_walk_top.sv ====
/*
 * Linked-list walker top level
 * Connects the CSR block, the walker pipeline and the hash accumulator
 */

`timescale 1ns/1ps

module list_walk_top
(
    input  logic clk,
    input  logic reset,

    // CSR access from software
    input  list_walk_pkg::t_csr_wr csr_wr,
    input  logic [list_walk_pkg::CSR_IDX_BITS-1:0] csr_rd_idx,
    output logic [list_walk_pkg::CSR_DATA_BITS-1:0] csr_rd_data,

    // Host memory read channel
    output list_walk_pkg::t_rd_req rd_req,
    input  list_walk_pkg::t_rd_rsp rd_rsp,
    input  logic c0_alm_full,

    // Host memory write channel
    output list_walk_pkg::t_wr_req wr_req,
    input  logic c1_alm_full
);

    // CSR block outputs
    logic [list_walk_pkg::LINE_ADDR_BITS-1:0] result_line_addr;
    logic start;
    logic [list_walk_pkg::LINE_ADDR_BITS-1:0] start_line_addr;

    // Response decode outputs
    logic next_valid;
    logic [list_walk_pkg::LINE_ADDR_BITS-1:0] next_line_addr;
    logic end_of_list;
    logic data_en;
    logic [31:0] data_word;
    logic last_beat;

    // Status counters and the running hash
    logic [15:0] list_length;
    logic [15:0] data_count;
    logic [31:0] hash_value;

    csr_regs i_csr_regs
    (
        .clk              (clk),
        .csr_wr           (csr_wr),
        .csr_rd_idx       (csr_rd_idx),
        .list_length      (list_length),
        .data_count       (data_count),
        .csr_rd_data      (csr_rd_data),
        .result_line_addr (result_line_addr),
        .start            (start),
        .start_line_addr  (start_line_addr)
    );

    walk_fsm i_walk_fsm
    (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .end_of_list      (end_of_list),
        .last_beat        (last_beat),
        .c1_alm_full      (c1_alm_full),
        .result_line_addr (result_line_addr),
        .hash_value       (hash_value),
        .wr_req           (wr_req)
    );

    read_issuer i_read_issuer
    (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .start_line_addr (start_line_addr),
        .next_valid      (next_valid),
        .next_line_addr  (next_line_addr),
        .end_of_list     (end_of_list),
        .c0_alm_full     (c0_alm_full),
        .rd_req          (rd_req),
        .list_length     (list_length)
    );

    rsp_decode i_rsp_decode
    (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .rd_rsp         (rd_rsp),
        .next_valid     (next_valid),
        .next_line_addr (next_line_addr),
        .end_of_list    (end_of_list),
        .data_en        (data_en),
        .data_word      (data_word),
        .last_beat      (last_beat),
        .data_count     (data_count)
    );

    hash32 i_hash32
    (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .en         (data_en),
        .data_word  (data_word),
        .hash_value (hash_value)
    );

endmodule

// ==== walker/hash32.sv ====
/*
 * 32-bit rotate-XOR hash accumulator
 */

`timescale 1ns/1ps

module hash32
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic en,
    input  logic [31:0] data_word,
    output logic [31:0] hash_value
);

    // Old value rotated left by 5, then mixed with the new word
    logic [31:0] hash_next;

    assign hash_next = {hash_value[26:0], hash_value[31:27]} ^ data_word;

    always_ff @(posedge clk)
    begin
        // Each walk hashes from zero
        if (reset || start)
        begin
            hash_value <= '0;
        end
        else if (en)
        begin
            hash_value <= hash_next;
        end
    end

endmodule

// ==== walker/read_issuer.sv ====
/*
 * Record read issuer
 * Holds the pending record read under back-pressure and counts issued reads
 */

`timescale 1ns/1ps

module read_issuer
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [list_walk_pkg::LINE_ADDR_BITS-1:0] start_line_addr,
    input  logic next_valid,
    input  logic [list_walk_pkg::LINE_ADDR_BITS-1:0] next_line_addr,
    input  logic end_of_list,
    input  logic c0_alm_full,
    output list_walk_pkg::t_rd_req rd_req,
    output logic [15:0] list_length
);

    // A read is owed to the host but has not been sent yet
    logic rd_needed;
    logic [list_walk_pkg::LINE_ADDR_BITS-1:0] rd_addr;
    logic issue;

    // The channel state is sampled one cycle ahead of the request it allows
    assign issue = rd_needed && !c0_alm_full;

    // ==================================================
    // Pending read
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_needed <= 1'b0;
        end
        else if (rd_needed)
        begin
            // Stays pending for as long as the read channel is almost full
            rd_needed <= c0_alm_full;
        end
        else
        begin
            // A walk starts, or a record pointed somewhere other than NULL
            rd_needed <= start || (next_valid && !end_of_list);
        end

        // The address is frozen while a read is pending.
        // Only one record is in flight, so nothing can overwrite it early
        if (!rd_needed)
        begin
            rd_addr <= start ? start_line_addr : next_line_addr;
        end
    end

    // ==================================================
    // Request register and read counter
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_req.valid <= 1'b0;
            list_length <= '0;
        end
        else
        begin
            rd_req.valid <= issue;
            // Not cleared on start, it accumulates over every walk
            if (issue)
            begin
                list_length <= list_length + 16'd1;
            end
        end

        rd_req.line_addr <= rd_addr;
    end

endmodule

// ==== walker/rsp_decode.sv ====
/*
 * Read response decoder
 * Splits record lines into next pointers and data words and counts the data
 */

`timescale 1ns/1ps

module rsp_decode
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  list_walk_pkg::t_rd_rsp rd_rsp,
    output logic next_valid,
    output logic [list_walk_pkg::LINE_ADDR_BITS-1:0] next_line_addr,
    output logic end_of_list,
    output logic data_en,
    output logic [31:0] data_word,
    output logic last_beat,
    output logic [15:0] data_count
);

    list_walk_pkg::t_line_word low_word;
    logic [list_walk_pkg::LINE_ADDR_BITS-1:0] ptr_line_addr;
    logic is_ptr_line;
    logic is_last_line;

    assign low_word = rd_rsp.data[63:0];

    // Pointer line address taken above the byte-offset bits, which are always zero
    assign ptr_line_addr =
        low_word.next.byte_addr[list_walk_pkg::BYTE_IDX_BITS +: list_walk_pkg::LINE_ADDR_BITS];

    // Beat 0 carries the pointer, every other beat carries data
    assign is_ptr_line = rd_rsp.valid && (rd_rsp.cl_num == '0);
    assign is_last_line = rd_rsp.valid &&
        (rd_rsp.cl_num == list_walk_pkg::t_cl_num'(list_walk_pkg::LINES_PER_RECORD - 1));

    // ==================================================
    // Decode registers
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_valid <= 1'b0;
            end_of_list <= 1'b0;
            data_en <= 1'b0;
            last_beat <= 1'b0;
        end
        else
        begin
            next_valid <= is_ptr_line;
            // A NULL pointer closes the list in the same cycle as next_valid
            end_of_list <= is_ptr_line && (ptr_line_addr == '0);
            data_en <= rd_rsp.valid && !is_ptr_line;
            // Final data word of the record
            last_beat <= is_last_line;
        end

        next_line_addr <= ptr_line_addr;
        data_word <= low_word.word.value;
    end

    // ==================================================
    // Data word counter
    // ==================================================

    always_ff @(posedge clk)
    begin
        // Counts the words of one walk and restarts on start
        if (reset || start)
        begin
            data_count <= '0;
        end
        else if (data_en)
        begin
            data_count <= data_count + 16'd1;
        end
    end

endmodule

// ==== walker/walk_fsm.sv ====
/*
 * Walker traversal FSM
 * Tracks a walk from start to the end of the list and issues the result write
 */

`timescale 1ns/1ps

module walk_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic end_of_list,
    input  logic last_beat,
    input  logic c1_alm_full,
    input  logic [list_walk_pkg::LINE_ADDR_BITS-1:0] result_line_addr,
    input  logic [31:0] hash_value,
    output list_walk_pkg::t_wr_req wr_req
);

    list_walk_pkg::t_walk_state state;

    // ==================================================
    // State register
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= list_walk_pkg::ST_IDLE;
        end
        else
        begin
            case (state)
                list_walk_pkg::ST_IDLE:
                begin
                    // A CSR 1 write kicks off the walk
                    if (start)
                    begin
                        state <= list_walk_pkg::ST_RUN;
                    end
                end

                list_walk_pkg::ST_RUN:
                begin
                    // A NULL next pointer has been seen in line 0 of a record
                    if (end_of_list)
                    begin
                        state <= list_walk_pkg::ST_END_OF_LIST;
                    end
                end

                list_walk_pkg::ST_END_OF_LIST:
                begin
                    // The last record still has data lines in flight, so wait
                    // for its final beat before the hash is complete
                    if (last_beat)
                    begin
                        state <= list_walk_pkg::ST_WRITE_RESULT;
                    end
                end

                list_walk_pkg::ST_WRITE_RESULT:
                begin
                    // The write is registered in the cycle the channel is open
                    if (!c1_alm_full)
                    begin
                        state <= list_walk_pkg::ST_IDLE;
                    end
                end

                default:
                begin
                    state <= list_walk_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Result write
    // ==================================================

    // Exactly one valid cycle per walk, and only when the write channel
    // was not almost full in the cycle before
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_req.valid <= 1'b0;
        end
        else
        begin
            wr_req.valid <= (state == list_walk_pkg::ST_WRITE_RESULT) && !c1_alm_full;
        end

        wr_req.line_addr <= result_line_addr;
        // Software spins on the nonzero flag in the low word and reads the hash above it
        wr_req.data <= {{(list_walk_pkg::LINE_BITS - 96){1'b0}}, hash_value, 64'd1};
    end

endmodule
